/* csr_pkg.sv */
/*
 * CSR address map and CSR operation enum
 * pmp configuration byte layout
 * SYSTEM opcode and funct3 encodings of the Zicsr instructions
 */
package csr_pkg;

    localparam int XLEN = 32;                   // data path width

    // user level registers
    localparam logic [11:0] USTATUS_A = 12'h000;
    localparam logic [11:0] UIE_A     = 12'h004;
    localparam logic [11:0] UTVEC_A   = 12'h005;

    // pmp configuration, four bytes per word
    localparam logic [11:0] PMPCFG0_A = 12'h3A0;
    localparam logic [11:0] PMPCFG1_A = 12'h3A1;
    localparam logic [11:0] PMPCFG2_A = 12'h3A2;
    localparam logic [11:0] PMPCFG3_A = 12'h3A3;

    localparam logic [11:0] MCYCLE_A  = 12'hB00;    // machine cycle counter

    // operation applied to the addressed CSR
    typedef enum logic [1:0]
    {
        CSR_NONE = 2'b00,
        CSR_WR   = 2'b01,
        CSR_SET  = 2'b10,
        CSR_CLR  = 2'b11
    } csr_op_e;

    // one pmp entry configuration byte
    typedef struct packed
    {
        logic       lock;       // entry locked
        logic [1:0] reserved;
        logic [1:0] addr_mode;  // off, tor, na4, napot
        logic       exec;
        logic       write;
        logic       read;
    } pmp_cfg_t;

    localparam logic [6:0] SYSTEM_OPCODE = 7'b1110011;

    // funct3 of the CSR instructions, bit 2 selects the uimm form
    localparam logic [2:0] FUNCT3_CSRRW  = 3'b001;
    localparam logic [2:0] FUNCT3_CSRRS  = 3'b010;
    localparam logic [2:0] FUNCT3_CSRRC  = 3'b011;
    localparam logic [2:0] FUNCT3_CSRRWI = 3'b101;
    localparam logic [2:0] FUNCT3_CSRRSI = 3'b110;
    localparam logic [2:0] FUNCT3_CSRRCI = 3'b111;

endpackage : csr_pkg

/* pipe_pkg.sv */
/*
 * CSR request and response structs
 * request FIFO depth and pointer width
 * phase enum shared by the four-phase req/ack links
 */
package pipe_pkg;

    localparam int REQ_FIFO_DEPTH = 4;
    localparam int REQ_FIFO_AW    = $clog2(REQ_FIFO_DEPTH);   // pointer width

    // decoded CSR access, decoder to CSR file
    typedef struct packed
    {
        logic [11:0]                addr;
        csr_pkg::csr_op_e           op;
        logic [csr_pkg::XLEN-1:0]   wdata;
        logic [4:0]                 rd;
        logic                       wr_en;      // write allowed
        logic                       illegal;    // not a CSR instruction
    } csr_req_t;

    // result returned to the core
    typedef struct packed
    {
        logic [4:0]                 rd;
        logic [csr_pkg::XLEN-1:0]   rdata;      // old CSR value
        logic                       illegal;
    } csr_rsp_t;

    // four-phase handshake phase
    typedef enum logic [1:0]
    {
        HS_IDLE      = 2'b00,
        HS_REQ       = 2'b01,
        HS_WAIT_DROP = 2'b10
    } hs_phase_e;

endpackage : pipe_pkg

/* csr_instr_decoder.sv */
/*
 * SYSTEM instruction decoder, turns instruction and rs1 into a CSR request
 * four-phase receiver on the instruction link, sender on the push link
 */
`timescale 1ns/1ps

module csr_instr_decoder
(
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        instr_req_i,
    input  logic [31:0]                 instr_i,
    input  logic [csr_pkg::XLEN-1:0]    rs1_val_i,
    output logic                        instr_ack_o,
    output logic                        push_req_o,
    output pipe_pkg::csr_req_t          push_data_o,
    input  logic                        push_ack_i
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [4:0]             rs1_field;     // rs1 index or uimm
    pipe_pkg::csr_req_t     dec_req;
    pipe_pkg::hs_phase_e    in_phase;
    pipe_pkg::hs_phase_e    out_phase;
    logic                   hold_full;     // holding register occupied
    logic                   capture;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign rs1_field = instr_i[19:15];

    always_comb
    begin
        dec_req       = '0;
        dec_req.addr  = instr_i[31:20];
        dec_req.rd    = instr_i[11:7];
        dec_req.wdata = funct3[2] ? {{(csr_pkg::XLEN-5){1'b0}}, rs1_field} : rs1_val_i;
        dec_req.op    = csr_pkg::CSR_NONE;
        if (opcode == csr_pkg::SYSTEM_OPCODE)
        begin
            case (funct3)
                csr_pkg::FUNCT3_CSRRW, csr_pkg::FUNCT3_CSRRWI : dec_req.op = csr_pkg::CSR_WR;
                csr_pkg::FUNCT3_CSRRS, csr_pkg::FUNCT3_CSRRSI : dec_req.op = csr_pkg::CSR_SET;
                csr_pkg::FUNCT3_CSRRC, csr_pkg::FUNCT3_CSRRCI : dec_req.op = csr_pkg::CSR_CLR;
                default : ;                             // ecall/ebreak and 3'b100
            endcase
        end
        dec_req.illegal = (dec_req.op == csr_pkg::CSR_NONE);
        // set/clear with x0 or uimm 0 only read
        dec_req.wr_en   = (dec_req.op == csr_pkg::CSR_WR) ||
                          ((dec_req.op != csr_pkg::CSR_NONE) && (rs1_field != 5'd0));
    end

    assign capture = instr_req_i && (in_phase == pipe_pkg::HS_IDLE) && !hold_full;

    // instruction side, ack held until req drops
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            in_phase <= pipe_pkg::HS_IDLE;
        else
        begin
            case (in_phase)
                pipe_pkg::HS_IDLE :
                    if (capture)
                        in_phase <= pipe_pkg::HS_WAIT_DROP;
                pipe_pkg::HS_WAIT_DROP :
                    if (!instr_req_i)
                        in_phase <= pipe_pkg::HS_IDLE;
                default :
                    in_phase <= pipe_pkg::HS_IDLE;
            endcase
        end
    end

    // push side
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            out_phase <= pipe_pkg::HS_IDLE;
            hold_full <= 1'b0;
        end
        else
        begin
            if (capture)
                hold_full <= 1'b1;
            case (out_phase)
                pipe_pkg::HS_IDLE :
                    if (hold_full)
                        out_phase <= pipe_pkg::HS_REQ;
                pipe_pkg::HS_REQ :
                    if (push_ack_i)
                    begin
                        out_phase <= pipe_pkg::HS_WAIT_DROP;
                        hold_full <= 1'b0;      // FIFO has the entry
                    end
                pipe_pkg::HS_WAIT_DROP :
                    if (!push_ack_i)
                        out_phase <= pipe_pkg::HS_IDLE;
                default :
                    out_phase <= pipe_pkg::HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (capture)
            push_data_o <= dec_req;
    end

    assign instr_ack_o = (in_phase == pipe_pkg::HS_WAIT_DROP);
    assign push_req_o  = (out_phase == pipe_pkg::HS_REQ);

endmodule : csr_instr_decoder

/* csr_req_fifo.sv */
/*
 * four entry CSR request queue
 * independent four-phase handshakes on push and pop sides
 */
`timescale 1ns/1ps

module csr_req_fifo
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                push_req_i,
    input  pipe_pkg::csr_req_t  push_data_i,
    output logic                push_ack_o,
    output logic                pop_req_o,
    output pipe_pkg::csr_req_t  pop_data_o,
    input  logic                pop_ack_i
);

    pipe_pkg::csr_req_t                 mem [pipe_pkg::REQ_FIFO_DEPTH];
    logic [pipe_pkg::REQ_FIFO_AW-1:0]   wr_ptr;
    logic [pipe_pkg::REQ_FIFO_AW-1:0]   rd_ptr;
    logic [pipe_pkg::REQ_FIFO_AW:0]     count;
    pipe_pkg::hs_phase_e                push_phase;
    pipe_pkg::hs_phase_e                pop_phase;
    logic                               full;
    logic                               empty;
    logic                               push_fire;
    logic                               pop_fire;

    assign full  = (count == pipe_pkg::REQ_FIFO_DEPTH);
    assign empty = (count == '0);

    assign push_fire = push_req_i && (push_phase == pipe_pkg::HS_IDLE) && !full;
    assign pop_fire  = pop_req_o && pop_ack_i;

    always_ff @(posedge clk)
    begin
        if (push_fire)
            mem[wr_ptr] <= push_data_i;
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_fire)
                wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two
            if (pop_fire)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push_fire, pop_fire})
                2'b10   : count <= count + 1'b1;
                2'b01   : count <= count - 1'b1;
                default : ;
            endcase
        end
    end

    // push phase and pop phase
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            push_phase <= pipe_pkg::HS_IDLE;
            pop_phase  <= pipe_pkg::HS_IDLE;
        end
        else
        begin
            if (push_fire)
                push_phase <= pipe_pkg::HS_WAIT_DROP;
            else if ((push_phase == pipe_pkg::HS_WAIT_DROP) && !push_req_i)
                push_phase <= pipe_pkg::HS_IDLE;
            if (pop_fire)
                pop_phase <= pipe_pkg::HS_WAIT_DROP;
            else if ((pop_phase == pipe_pkg::HS_WAIT_DROP) && !pop_ack_i)
                pop_phase <= pipe_pkg::HS_IDLE;     // next entry may be offered
        end
    end

    assign push_ack_o = (push_phase == pipe_pkg::HS_WAIT_DROP);
    assign pop_req_o  = !empty && (pop_phase == pipe_pkg::HS_IDLE);
    assign pop_data_o = mem[rd_ptr];

endmodule : csr_req_fifo

/* csr_file.sv */
/*
 * CSR register file: ustatus, uie, utvec, pmpcfg0-3 and mcycle
 * applies write/set/clear and returns the old value as a response
 */
`timescale 1ns/1ps

module csr_file
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                pop_req_i,
    input  pipe_pkg::csr_req_t  pop_data_i,
    output logic                pop_ack_o,
    output logic                rsp_req_o,
    output pipe_pkg::csr_rsp_t  rsp_o,
    input  logic                rsp_ack_i
);

    logic [csr_pkg::XLEN-1:0]       ustatus;
    logic [csr_pkg::XLEN-1:0]       uie;
    logic [csr_pkg::XLEN-1:0]       utvec;
    logic [csr_pkg::XLEN-1:0]       mcycle;
    csr_pkg::pmp_cfg_t [3:0][3:0]   pmp_cfg;    // [word][byte]
    logic [csr_pkg::XLEN-1:0]       old_val;
    logic [csr_pkg::XLEN-1:0]       new_val;
    logic                           addr_ok;    // address implemented
    logic                           take;
    logic                           do_write;
    logic                           rsp_full;   // response slot occupied
    pipe_pkg::hs_phase_e            pop_phase;
    pipe_pkg::hs_phase_e            rsp_phase;

    assign take     = pop_req_i && (pop_phase == pipe_pkg::HS_IDLE) && !rsp_full;
    assign do_write = take && pop_data_i.wr_en && addr_ok;

    // read mux
    always_comb
    begin
        old_val = '0;
        addr_ok = 1'b1;
        case (pop_data_i.addr)
            csr_pkg::USTATUS_A : old_val = ustatus;
            csr_pkg::UIE_A     : old_val = uie;
            csr_pkg::UTVEC_A   : old_val = utvec;
            csr_pkg::PMPCFG0_A : old_val = pmp_cfg[0];
            csr_pkg::PMPCFG1_A : old_val = pmp_cfg[1];
            csr_pkg::PMPCFG2_A : old_val = pmp_cfg[2];
            csr_pkg::PMPCFG3_A : old_val = pmp_cfg[3];
            csr_pkg::MCYCLE_A  : old_val = mcycle;
            default            : addr_ok = 1'b0;
        endcase
    end

    always_comb
    begin
        case (pop_data_i.op)
            csr_pkg::CSR_SET : new_val = old_val | pop_data_i.wdata;
            csr_pkg::CSR_CLR : new_val = old_val & ~pop_data_i.wdata;
            default          : new_val = pop_data_i.wdata;
        endcase
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            ustatus <= '0;
            uie     <= '0;
            utvec   <= '0;
            pmp_cfg <= '0;
        end
        else if (do_write)
        begin
            case (pop_data_i.addr)
                csr_pkg::USTATUS_A : ustatus    <= new_val;
                csr_pkg::UIE_A     : uie        <= new_val;
                csr_pkg::UTVEC_A   : utvec      <= new_val;
                csr_pkg::PMPCFG0_A : pmp_cfg[0] <= new_val;
                csr_pkg::PMPCFG1_A : pmp_cfg[1] <= new_val;
                csr_pkg::PMPCFG2_A : pmp_cfg[2] <= new_val;
                csr_pkg::PMPCFG3_A : pmp_cfg[3] <= new_val;
                default            : ;          // mcycle below
            endcase
        end
    end

    // free running, a write replaces the increment
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            mcycle <= '0;
        else if (do_write && (pop_data_i.addr == csr_pkg::MCYCLE_A))
            mcycle <= new_val;
        else
            mcycle <= mcycle + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            rsp_o.rd      <= pop_data_i.rd;
            rsp_o.rdata   <= (addr_ok && !pop_data_i.illegal) ? old_val : '0;
            rsp_o.illegal <= pop_data_i.illegal || !addr_ok;
        end
    end

    // pop side, ack until FIFO drops req
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            pop_phase <= pipe_pkg::HS_IDLE;
        else if (take)
            pop_phase <= pipe_pkg::HS_WAIT_DROP;
        else if ((pop_phase == pipe_pkg::HS_WAIT_DROP) && !pop_req_i)
            pop_phase <= pipe_pkg::HS_IDLE;
    end

    // response side
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            rsp_phase <= pipe_pkg::HS_IDLE;
            rsp_full  <= 1'b0;
        end
        else
        begin
            if (take)
                rsp_full <= 1'b1;
            case (rsp_phase)
                pipe_pkg::HS_IDLE :
                    if (rsp_full)
                        rsp_phase <= pipe_pkg::HS_REQ;
                pipe_pkg::HS_REQ :
                    if (rsp_ack_i)
                        rsp_phase <= pipe_pkg::HS_WAIT_DROP;
                pipe_pkg::HS_WAIT_DROP :
                    if (!rsp_ack_i)
                    begin
                        rsp_phase <= pipe_pkg::HS_IDLE;
                        rsp_full  <= 1'b0;      // slot free again
                    end
                default :
                    rsp_phase <= pipe_pkg::HS_IDLE;
            endcase
        end
    end

    assign pop_ack_o = (pop_phase == pipe_pkg::HS_WAIT_DROP);
    assign rsp_req_o = (rsp_phase == pipe_pkg::HS_REQ);

endmodule : csr_file

/* csr_unit_top.sv */
/*
 * CSR unit top: decoder, request FIFO and CSR file
 */
`timescale 1ns/1ps

module csr_unit_top
(
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        instr_req_i,
    input  logic [31:0]                 instr_i,
    input  logic [csr_pkg::XLEN-1:0]    rs1_val_i,
    output logic                        instr_ack_o,
    output logic                        rsp_req_o,
    output pipe_pkg::csr_rsp_t          rsp_o,
    input  logic                        rsp_ack_i
);

    logic                   push_req;
    logic                   push_ack;
    pipe_pkg::csr_req_t     push_data;
    logic                   pop_req;
    logic                   pop_ack;
    pipe_pkg::csr_req_t     pop_data;

    csr_instr_decoder u_decoder
    (
        .clk            ( clk           ),
        .resetn         ( resetn        ),
        .instr_req_i    ( instr_req_i   ),
        .instr_i        ( instr_i       ),
        .rs1_val_i      ( rs1_val_i     ),
        .instr_ack_o    ( instr_ack_o   ),
        .push_req_o     ( push_req      ),
        .push_data_o    ( push_data     ),
        .push_ack_i     ( push_ack      )
    );

    csr_req_fifo u_fifo
    (
        .clk            ( clk           ),
        .resetn         ( resetn        ),
        .push_req_i     ( push_req      ),
        .push_data_i    ( push_data     ),
        .push_ack_o     ( push_ack      ),
        .pop_req_o      ( pop_req       ),
        .pop_data_o     ( pop_data      ),
        .pop_ack_i      ( pop_ack       )
    );

    csr_file u_csr
    (
        .clk            ( clk           ),
        .resetn         ( resetn        ),
        .pop_req_i      ( pop_req       ),
        .pop_data_i     ( pop_data      ),
        .pop_ack_o      ( pop_ack       ),
        .rsp_req_o      ( rsp_req_o     ),
        .rsp_o          ( rsp_o         ),
        .rsp_ack_i      ( rsp_ack_i     )
    );

endmodule : csr_unit_top

/* tb_csr_tasks.svh */
/*
 * reference model with shadow CSRs and expected response queue
 * instruction encoder and four-phase instruction sender
 */

// one expected response
typedef struct packed
{
    logic [4:0]  rd;
    logic [31:0] rdata;
    logic        illegal;
    logic        is_cycle;      // mcycle value, checked against a floor
    logic        cycle_wr;      // mcycle loaded with cycle_val
    logic [31:0] cycle_val;
} exp_rsp_t;

exp_rsp_t    exp_q [$];
logic [31:0] shadow [7] = '{default: '0};   // zero like the CSRs after reset
logic [31:0] cycle_floor = '0;              // last known mcycle value
logic [11:0] reg_addr [7] = '{csr_pkg::USTATUS_A, csr_pkg::UIE_A, csr_pkg::UTVEC_A,
                              csr_pkg::PMPCFG0_A, csr_pkg::PMPCFG1_A, csr_pkg::PMPCFG2_A,
                              csr_pkg::PMPCFG3_A};

// shadow slot of an address, 7 for mcycle, -1 when not implemented
function automatic int reg_index(input logic [11:0] addr);
    int idx;
    idx = -1;
    foreach (reg_addr[i])
        if (reg_addr[i] == addr)
            idx = i;
    if (addr == csr_pkg::MCYCLE_A)
        idx = 7;
    return idx;
endfunction

function automatic logic [31:0] encode_csr(input logic [11:0] addr, input logic [4:0] field,
                                           input logic [2:0] funct3, input logic [4:0] rd);
    return {addr, field, funct3, rd, csr_pkg::SYSTEM_OPCODE};
endfunction

// applies one instruction to the shadow state and queues its response
task automatic predict(input logic [31:0] instr, input logic [31:0] rs1);
    exp_rsp_t    e;
    int          idx;
    logic [2:0]  f3;
    logic [4:0]  field;
    logic [31:0] operand;
    logic        write;
    f3      = instr[14:12];
    field   = instr[19:15];
    idx     = reg_index(instr[31:20]);
    operand = f3[2] ? {27'd0, field} : rs1;     // uimm forms
    write   = (f3[1:0] == 2'b01) || (field != 5'd0);
    e       = '0;
    e.rd    = instr[11:7];
    if ((instr[6:0] != csr_pkg::SYSTEM_OPCODE) || (f3[1:0] == 2'b00) || (idx < 0))
        e.illegal = 1'b1;
    else if (idx == 7)
    begin
        e.is_cycle  = 1'b1;
        e.cycle_wr  = write && (f3[1:0] == 2'b01);
        e.cycle_val = operand;
    end
    else
    begin
        e.rdata = shadow[idx];
        if (write)
        begin
            case (f3[1:0])
                2'b01   : shadow[idx] = operand;
                2'b10   : shadow[idx] = shadow[idx] | operand;
                default : shadow[idx] = shadow[idx] & ~operand;
            endcase
        end
    end
    exp_q.push_back(e);
endtask

// full four-phase cycle on the instruction link
task automatic send_instr(input logic [31:0] instr, input logic [31:0] rs1);
    predict(instr, rs1);
    instr_req_i <= 1'b1;
    instr_i     <= instr;
    rs1_val_i   <= rs1;
    do
        @(posedge clk);
    while (!instr_ack_o);
    instr_req_i <= 1'b0;
    accepted++;
    do
        @(posedge clk);
    while (instr_ack_o);
endtask

/* tb_csr_unit.sv */
/*
 * testbench for the CSR unit: clock, reset, DUT, response checks
 * handshake protocol monitor used on all four links
 */
`timescale 1ns/1ps

module tb_csr_unit;

    localparam int N_RESET = 7;
    localparam int N_RAND  = 40;
    localparam int N_ILL   = 12;
    localparam int N_CYCLE = 4;
    localparam int N_BP    = 8;
    localparam int TIMEOUT = 20 * (N_RESET + N_RAND + N_ILL + N_CYCLE + N_BP) + 200;

    logic               clk = 1'b0;
    logic               resetn;
    logic               instr_req_i;
    logic [31:0]        instr_i;
    logic [31:0]        rs1_val_i;
    logic               instr_ack_o;
    logic               rsp_req_o;
    pipe_pkg::csr_rsp_t rsp_o;
    logic               rsp_ack_i;

    integer seed = 3634;
    int     err_cnt = 0;
    int     accepted = 0;           // instructions acked so far
    int     cycle_cnt = 0;
    int     tests_failed = 0;
    int     errs_at_start = 0;
    int     link_fails [4];
    logic   hold_rsp = 1'b0;        // response back-pressure

    `include "tb_csr_tasks.svh"

    always #2 clk = ~clk;

    csr_unit_top u_dut
    (
        .clk            ( clk           ),
        .resetn         ( resetn        ),
        .instr_req_i    ( instr_req_i   ),
        .instr_i        ( instr_i       ),
        .rs1_val_i      ( rs1_val_i     ),
        .instr_ack_o    ( instr_ack_o   ),
        .rsp_req_o      ( rsp_req_o     ),
        .rsp_o          ( rsp_o         ),
        .rsp_ack_i      ( rsp_ack_i     )
    );

    handshake_monitor u_instr_hs (clk, resetn, instr_req_i, instr_ack_o, link_fails[0]);
    handshake_monitor u_push_hs (clk, resetn, u_dut.push_req, u_dut.push_ack, link_fails[1]);
    handshake_monitor u_pop_hs (clk, resetn, u_dut.pop_req, u_dut.pop_ack, link_fails[2]);
    handshake_monitor u_rsp_hs (clk, resetn, rsp_req_o, rsp_ack_i, link_fails[3]);

    function automatic int total_errors();
        return err_cnt + link_fails[0] + link_fails[1] + link_fails[2] + link_fails[3];
    endfunction

    task automatic value_error(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        err_cnt++;
    endtask

    task automatic finish_test(input string name);
        if (total_errors() == errs_at_start)
            $display("test %-24s pass", name);
        else
        begin
            $display("test %-24s fail", name);
            tests_failed++;
        end
        errs_at_start = total_errors();
    endtask

    task automatic check_response();
        exp_rsp_t e;
        if (exp_q.size() == 0)
        begin
            $display("response at %0t ns arrived with no instruction outstanding", $time);
            err_cnt++;
        end
        else
        begin
            e = exp_q.pop_front();
            assert (rsp_o.rd == e.rd)
                else value_error("rd", rsp_o.rd, e.rd);
            assert (rsp_o.illegal == e.illegal)
                else value_error("illegal flag", rsp_o.illegal, e.illegal);
            if (e.is_cycle)
            begin
                assert (rsp_o.rdata > cycle_floor)
                    else value_error("mcycle above floor", rsp_o.rdata, cycle_floor + 1);
                cycle_floor = e.cycle_wr ? e.cycle_val : rsp_o.rdata;
            end
            else
            begin
                assert (rsp_o.rdata == e.rdata)
                    else value_error("rdata", rsp_o.rdata, e.rdata);
            end
        end
    endtask

    task automatic read_all_regs(input logic [2:0] funct3, input logic [31:0] rs1);
        foreach (reg_addr[i])
            send_instr(encode_csr(reg_addr[i], 5'd0, funct3, 5'(i + 1)), rs1);
    endtask

    // legal op on one of the plain registers, uimm/rs1 field zero a quarter of the time
    task automatic random_reg_op();
        logic [2:0] f3;
        logic [4:0] field;
        f3    = {1'($random(seed)), 2'(1 + $unsigned($random(seed)) % 3)};
        field = ($unsigned($random(seed)) % 4 == 0) ? 5'd0 : 5'($random(seed));
        send_instr(encode_csr(reg_addr[$unsigned($random(seed)) % 7], field, f3,
                              5'($random(seed))), $random(seed));
    endtask

    task automatic wait_drain();
        while ((exp_q.size() != 0) || rsp_ack_i)
            @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    // response side, random ack delay
    initial
    begin
        forever
        begin
            @(posedge clk);
            if (rsp_req_o && !hold_rsp)
            begin
                check_response();
                repeat ($unsigned($random(seed)) % 3) @(posedge clk);
                rsp_ack_i <= 1'b1;
                do
                    @(posedge clk);
                while (rsp_req_o);
                rsp_ack_i <= 1'b0;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Some tests failed");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] cycle_v;
        resetn      <= 1'b0;
        instr_req_i <= 1'b0;
        instr_i     <= '0;
        rs1_val_i   <= '0;
        rsp_ack_i   <= 1'b0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);

        assert (!instr_ack_o && !rsp_req_o)
            else
            begin
                $display("handshake outputs not low after reset at %0t ns", $time);
                err_cnt++;
            end
        read_all_regs(csr_pkg::FUNCT3_CSRRS, 32'hFFFF_FFFF);    // x0 set, no write
        wait_drain();
        finish_test("reset and read back");

        repeat (N_RAND) random_reg_op();
        wait_drain();
        finish_test("write set clear");

        send_instr({12'h000, 5'd1, csr_pkg::FUNCT3_CSRRW, 5'd3, 7'b0110011}, 32'hDEAD_BEEF);
        send_instr(encode_csr(csr_pkg::UIE_A, 5'd2, 3'b000, 5'd4), $random(seed));
        send_instr(encode_csr(csr_pkg::UTVEC_A, 5'd5, 3'b100, 5'd5), $random(seed));
        send_instr(encode_csr(12'h7C0, 5'd6, csr_pkg::FUNCT3_CSRRW, 5'd6), $random(seed));
        send_instr(encode_csr(12'h7C1, 5'd7, csr_pkg::FUNCT3_CSRRSI, 5'd7), $random(seed));
        read_all_regs(csr_pkg::FUNCT3_CSRRC, 32'hFFFF_FFFF);    // state untouched
        wait_drain();
        finish_test("illegal instructions");

        cycle_v = 32'h4000_0000 | ($random(seed) & 32'h0FFF_FFFF);
        send_instr(encode_csr(csr_pkg::MCYCLE_A, 5'd0, csr_pkg::FUNCT3_CSRRS, 5'd8), '0);
        send_instr(encode_csr(csr_pkg::MCYCLE_A, 5'd0, csr_pkg::FUNCT3_CSRRS, 5'd9), '0);
        send_instr(encode_csr(csr_pkg::MCYCLE_A, 5'd1, csr_pkg::FUNCT3_CSRRW, 5'd10), cycle_v);
        send_instr(encode_csr(csr_pkg::MCYCLE_A, 5'd0, csr_pkg::FUNCT3_CSRRS, 5'd11), '0);
        wait_drain();
        finish_test("mcycle");

        hold_rsp <= 1'b1;
        accepted = 0;
        fork
            repeat (N_BP) random_reg_op();
            begin
                repeat (60) @(posedge clk);
                assert ((accepted == 6) && instr_req_i && !instr_ack_o)
                    else
                    begin
                        $display("back-pressure: %0d instructions accepted instead of 6",
                                 accepted);
                        err_cnt++;
                    end
                hold_rsp <= 1'b0;
            end
        join
        wait_drain();
        finish_test("back-pressure and order");

        $display("tests run: 5, tests failing: %0d, failed checks: %0d",
                 tests_failed, total_errors());
        if ((total_errors() == 0) && (tests_failed == 0))
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule : tb_csr_unit

// four-phase rules on one req/ack link
module handshake_monitor
(
    input  logic clk,
    input  logic resetn,
    input  logic req_i,
    input  logic ack_i,
    output int   fail_cnt_o
);

    int fails = 0;

    assign fail_cnt_o = fails;

    req_hold : assert property (@(posedge clk) disable iff (!resetn) req_i && !ack_i |=> req_i)
        else
        begin
            $display("protocol error at %0t ns in %m: req fell before ack", $time);
            fails++;
        end

    ack_hold : assert property (@(posedge clk) disable iff (!resetn) req_i && ack_i |=> ack_i)
        else
        begin
            $display("protocol error at %0t ns in %m: ack fell before req", $time);
            fails++;
        end

    // no new req while the old ack is still up
    req_wait : assert property (@(posedge clk) disable iff (!resetn) !req_i && ack_i |=> !req_i)
        else
        begin
            $display("protocol error at %0t ns in %m: req rose while ack high", $time);
            fails++;
        end

endmodule : handshake_monitor

/* list.f */
+incdir+.
csr_pkg.sv
pipe_pkg.sv
csr_instr_decoder.sv
csr_req_fifo.sv
csr_file.sv
csr_unit_top.sv
tb_csr_unit.sv

/* run.sh */
#!/usr/bin/env bash
# build the CSR unit testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_csr_unit -f list.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_csr_unit > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

! grep -q "Some tests failed" sim.log && grep -q "All tests passed" sim.log \
    && echo "simulation passed" || { echo "simulation failed"; exit 1; }
